/* src/dmaPkg.sv */
// SCSI DMA data path types

package dmaPkg;

    // The CPU/DMA bus and the FIFO both move whole 32-bit words
    // A word on either side carries the same layout, so one type covers both
    typedef logic [31:0] busWord;

    // The SCSI data port moves 16 bits per handshake
    // Two of these make up one bus word, high half first
    typedef logic [15:0] scsiHalf;

    // States of the SCSI word packer
    // The same machine serves both transfer directions
    //
    // idle      Waiting for the first request of a word
    //           Inbound it latches the high half here
    //           Outbound it presents the high half of the FIFO head
    //
    // highDone  Inbound only
    //           The high half is held and the machine waits for the second request
    //
    // waitFifo  A request is pending but the FIFO cannot take part yet
    //           Inbound this means the FIFO is full
    //           Outbound this means the FIFO is empty
    //
    // sendHigh  Outbound only
    //           The high half has been acked
    //           Once that ack drops the low half is presented
    //
    // sendLow   Outbound only
    //           The low half has been acked and the FIFO head was popped
    //           The machine returns to idle when the device drops its request
    typedef enum logic [2:0] {
        idle,
        highDone,
        waitFifo,
        sendHigh,
        sendLow
    } packState;

endpackage

/* src/cpuLaneLatch.sv */
// CPU bus lane latch

`timescale 1ns/1ps

module cpuLaneLatch (
    input  logic           CLK,
    input  logic           rst,
    input  dmaPkg::busWord busIn,
    input  logic           laneHigh,
    input  logic           laneLow,
    output dmaPkg::busWord cpuWord
);
    import dmaPkg::*;

    // Word that will be held after the next edge
    busWord nextWord;

    // Each 16-bit lane of the CPU bus has its own enable
    // A lane without its enable keeps what it held before
    // Both enables may be high together, which captures the full word at once
    always_comb begin
        nextWord = cpuWord;

        // Upper lane, bits 31 down to 16
        if (laneHigh) begin
            nextWord[31:16] = busIn[31:16];
        end

        // Lower lane, bits 15 down to 0
        if (laneLow) begin
            nextWord[15:0] = busIn[15:0];
        end
    end

    // The held word is visible one cycle after the enabling edge
    // It feeds the FIFO input mux when the CPU is the data source
    always_ff @(posedge CLK) begin
        if (rst) begin
            // Start from a known word so a partial lane write is predictable
            cpuWord <= '0;
        end else begin
            cpuWord <= nextWord;
        end
    end

endmodule

/* src/scsiWordPacker.sv */
// SCSI word packer

`timescale 1ns/1ps

module scsiWordPacker (
    input  logic            CLK,
    input  logic            rst,
    input  logic            s2f,
    input  logic            f2s,
    input  logic            scsiReq,
    output logic            scsiAck,
    input  dmaPkg::scsiHalf scsiIn,
    output dmaPkg::scsiHalf scsiOut,
    input  logic            fifoFull,
    input  logic            fifoEmpty,
    input  dmaPkg::busWord  fifoRdData,
    output logic            fifoRead,
    output dmaPkg::busWord  packedWord,
    output logic            packedValid
);
    import dmaPkg::*;

    packState state;

    // High half of an inbound word, waiting for its partner
    scsiHalf highHalf;

    // Handshake phases seen from the packer side
    logic newReq;
    logic reqGone;

    // Strobe for the inbound high half
    logic captureHigh;

    // Selects the low half of the FIFO head for the SCSI port
    logic lowSelect;

    // A request is new only while our ack is still low
    assign newReq  = scsiReq && !scsiAck;

    // The device has dropped its request and waits for our ack to fall
    assign reqGone = !scsiReq && scsiAck;

    // Inbound the high half comes first and is taken from idle
    assign captureHigh = (state == idle) && s2f && newReq;

    // The high half stays on the port while its ack is up
    // Once that ack has dropped the low half is shown until the word is done
    assign lowSelect = (state == sendLow) || ((state == sendHigh) && !scsiAck);

    assign scsiOut = lowSelect ? fifoRdData[15:0] : fifoRdData[31:16];

    // Only valid together with the state held in highDone or waitFifo
    always_ff @(posedge CLK) begin
        if (captureHigh) begin
            highHalf <= scsiIn;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state       <= idle;
            scsiAck     <= 1'b0;
            fifoRead    <= 1'b0;
            packedValid <= 1'b0;
            // CPU reads of SCSI data return zero before the first word
            packedWord  <= '0;
        end else begin
            // Both strobes are single-cycle pulses
            packedValid <= 1'b0;
            fifoRead    <= 1'b0;

            // Ack always follows the request down one cycle later, in any state
            if (reqGone) begin
                scsiAck <= 1'b0;
            end

            case (state)
                idle: begin
                    if (s2f && newReq) begin
                        // High half is latched by captureHigh on this edge
                        scsiAck <= 1'b1;
                        state   <= highDone;
                    end else if (f2s && newReq) begin
                        if (fifoEmpty) begin
                            // Nothing to send yet so hold the device off
                            state <= waitFifo;
                        end else begin
                            scsiAck <= 1'b1;
                            state   <= sendHigh;
                        end
                    end
                end

                highDone: begin
                    if (newReq) begin
                        if (fifoFull) begin
                            // Back-pressure withholds the second ack
                            state <= waitFifo;
                        end else begin
                            packedWord  <= {highHalf, scsiIn};
                            packedValid <= 1'b1;
                            scsiAck     <= 1'b1;
                            state       <= idle;
                        end
                    end
                end

                waitFifo: begin
                    if (s2f) begin
                        // Device keeps the low half stable while it waits
                        if (newReq && !fifoFull) begin
                            packedWord  <= {highHalf, scsiIn};
                            packedValid <= 1'b1;
                            scsiAck     <= 1'b1;
                            state       <= idle;
                        end
                    end else if (newReq && !fifoEmpty) begin
                        // Outbound word has arrived at the FIFO head
                        scsiAck <= 1'b1;
                        state   <= sendHigh;
                    end
                end

                sendHigh: begin
                    // Second request takes the low half and pops the word
                    if (newReq) begin
                        scsiAck  <= 1'b1;
                        fifoRead <= 1'b1;
                        state    <= sendLow;
                    end
                end

                sendLow: begin
                    // Low half stays selected until the device lets go
                    if (reqGone) begin
                        state <= idle;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase

            // With no direction selected a partial word is dropped
            if (!s2f && !f2s) begin
                state <= idle;
            end
        end
    end

endmodule

/* src/dataRouter.sv */
// Data path router

`timescale 1ns/1ps

module dataRouter (
    input  logic           CLK,
    input  logic           rst,
    input  logic           s2f,
    input  logic           s2cpu,
    input  dmaPkg::busWord cpuWord,
    input  dmaPkg::busWord packedWord,
    input  logic           packedValid,
    input  logic           cpuWrite,
    input  dmaPkg::busWord regData,
    input  logic           cpuSelect,
    input  logic           cpuRead,
    input  logic           busOwned,
    input  logic           dmaDir,
    output dmaPkg::busWord fifoIn,
    output logic           fifoWrite,
    output dmaPkg::busWord cpuRdData,
    output logic           dataOe
);

    // Bus drive request before the output register
    logic oeRequest;

    // FIFO input source
    // With s2f high the SCSI side fills the FIFO with packed words
    // Otherwise the CPU lane latch is the source
    assign fifoIn = s2f ? packedWord : cpuWord;

    // The write strobe comes from the same side as the data
    // packedValid already lines up with a fresh packedWord
    assign fifoWrite = s2f ? packedValid : cpuWrite;

    // CPU read data
    // s2cpu lets the CPU read the last word seen on the SCSI port
    // Otherwise it reads the register file
    assign cpuRdData = s2cpu ? packedWord : regData;

    // The data bus is driven in two cases
    // The CPU reads one of our registers while we are selected
    // Or we own the bus and the DMA moves data out toward memory
    assign oeRequest = (cpuSelect && cpuRead) || (busOwned && dmaDir);

    // Output enable is registered so the bus turns on one cycle late
    // This leaves the other driver a cycle to let go of the bus
    always_ff @(posedge CLK) begin
        if (rst) begin
            dataOe <= 1'b0;
        end else begin
            dataOe <= oeRequest;
        end
    end

endmodule

/* src/scsiDatapath.sv */
// SCSI DMA data path top

`timescale 1ns/1ps

module scsiDatapath (
    input  logic            CLK,
    input  logic            rst,
    input  dmaPkg::busWord  busIn,
    input  logic            laneHigh,
    input  logic            laneLow,
    input  logic            s2f,
    input  logic            f2s,
    input  logic            s2cpu,
    input  logic            scsiReq,
    output logic            scsiAck,
    input  dmaPkg::scsiHalf scsiIn,
    output dmaPkg::scsiHalf scsiOut,
    input  logic            fifoFull,
    input  logic            fifoEmpty,
    input  dmaPkg::busWord  fifoRdData,
    output logic            fifoRead,
    output dmaPkg::busWord  fifoIn,
    output logic            fifoWrite,
    input  logic            cpuWrite,
    input  dmaPkg::busWord  regData,
    input  logic            cpuSelect,
    input  logic            cpuRead,
    input  logic            busOwned,
    input  logic            dmaDir,
    output dmaPkg::busWord  cpuRdData,
    output logic            dataOe
);
    import dmaPkg::*;

    // Word held from the CPU bus
    busWord cpuWord;

    // Last word assembled from the SCSI port and its strobe
    busWord packedWord;
    logic   packedValid;

    // CPU side of the path
    cpuLaneLatch uLaneLatch (
        .CLK      (CLK      ),
        .rst      (rst      ),
        .busIn    (busIn    ),
        .laneHigh (laneHigh ),
        .laneLow  (laneLow  ),
        .cpuWord  (cpuWord  )
    );

    // SCSI side, handshake plus packing in both directions
    scsiWordPacker uPacker (
        .CLK         (CLK         ),
        .rst         (rst         ),
        .s2f         (s2f         ),
        .f2s         (f2s         ),
        .scsiReq     (scsiReq     ),
        .scsiAck     (scsiAck     ),
        .scsiIn      (scsiIn      ),
        .scsiOut     (scsiOut     ),
        .fifoFull    (fifoFull    ),
        .fifoEmpty   (fifoEmpty   ),
        .fifoRdData  (fifoRdData  ),
        .fifoRead    (fifoRead    ),
        .packedWord  (packedWord  ),
        .packedValid (packedValid )
    );

    // Merges both sides toward the FIFO and the CPU
    dataRouter uRouter (
        .CLK         (CLK         ),
        .rst         (rst         ),
        .s2f         (s2f         ),
        .s2cpu       (s2cpu       ),
        .cpuWord     (cpuWord     ),
        .packedWord  (packedWord  ),
        .packedValid (packedValid ),
        .cpuWrite    (cpuWrite    ),
        .regData     (regData     ),
        .cpuSelect   (cpuSelect   ),
        .cpuRead     (cpuRead     ),
        .busOwned    (busOwned    ),
        .dmaDir      (dmaDir      ),
        .fifoIn      (fifoIn      ),
        .fifoWrite   (fifoWrite   ),
        .cpuRdData   (cpuRdData   ),
        .dataOe      (dataOe      )
    );

endmodule

/* bench/scsiDatapath_checker.sv */
// SCSI data path checker

`timescale 1ns/1ps

module scsiDatapath_checker (
    input logic            CLK,
    input logic            rst,
    input dmaPkg::busWord  busIn,
    input logic            laneHigh,
    input logic            laneLow,
    input logic            s2f,
    input logic            f2s,
    input logic            s2cpu,
    input logic            scsiReq,
    input logic            scsiAck,
    input dmaPkg::scsiHalf scsiIn,
    input dmaPkg::scsiHalf scsiOut,
    input logic            fifoFull,
    input dmaPkg::busWord  fifoRdData,
    input logic            fifoRead,
    input dmaPkg::busWord  fifoIn,
    input logic            fifoWrite,
    input logic            cpuWrite,
    input dmaPkg::busWord  regData,
    input logic            cpuSelect,
    input logic            cpuRead,
    input logic            busOwned,
    input logic            dmaDir,
    input dmaPkg::busWord  cpuRdData,
    input logic            dataOe
);
    import dmaPkg::*;

    // Assertion failures, read by the testbench
    int errCount = 0;

    // Ack as seen at the previous edge, so a rise is scsiAck && !prevAck
    logic    prevAck;
    // Toggles on every acked half and is set while a word is half done
    logic    firstDone;
    logic    outFirstDone;
    scsiHalf highSeen;
    busWord  lastPacked;
    busWord  laneModel;
    logic    ackRise;
    // Bus enable that the decode asks for one cycle later
    logic    oeExpected;
    // Read data the CPU should see in this cycle
    busWord  rdExpected;

    assign ackRise = scsiAck && !prevAck;

    // A word packed in this very cycle has not reached lastPacked yet
    assign rdExpected = !s2cpu ? regData :
                        (s2f && fifoWrite) ? {highSeen, scsiIn} : lastPacked;

    always_ff @(posedge CLK) begin
        if (rst) begin
            prevAck      <= 1'b0;
            firstDone    <= 1'b0;
            outFirstDone <= 1'b0;
            lastPacked   <= '0;
            laneModel    <= '0;
            oeExpected   <= 1'b0;
        end else begin
            prevAck <= scsiAck;
            // Inbound halves arrive high first
            if (!s2f) begin
                firstDone <= 1'b0;
            end else if (ackRise) begin
                if (!firstDone) begin
                    highSeen <= scsiIn;
                end else begin
                    lastPacked <= {highSeen, scsiIn};
                end
                firstDone <= !firstDone;
            end
            if (!f2s) begin
                outFirstDone <= 1'b0;
            end else if (ackRise) begin
                outFirstDone <= !outFirstDone;
            end
            // Each lane of the CPU bus is kept on its own enable
            if (laneHigh) begin
                laneModel[31:16] <= busIn[31:16];
            end
            if (laneLow) begin
                laneModel[15:0] <= busIn[15:0];
            end
            // The bus is driven for a selected CPU read or an owned DMA write
            oeExpected <= (cpuSelect && cpuRead) || (busOwned && dmaDir);
        end
    end

    // Ack only follows the request in the four-phase handshake
    assert property (@(posedge CLK) disable iff (rst) $rose(scsiAck) |-> $past(scsiReq))
        else begin
            errCount++;
            $error("scsiAck rose while scsiReq was low");
        end
    assert property (@(posedge CLK) disable iff (rst) $fell(scsiAck) |-> !$past(scsiReq))
        else begin
            errCount++;
            $error("scsiAck fell while scsiReq was high");
        end

    // Control outputs are quiet right after reset
    assert property (@(posedge CLK) $past(rst) |->
        !scsiAck && !fifoRead && !fifoWrite && !dataOe)
        else begin
            errCount++;
            $error("Outputs not low after reset");
        end

    // A packed word is the two acked halves, high first
    assert property (@(posedge CLK) disable iff (rst)
        s2f && fifoWrite |-> firstDone && ackRise && fifoIn == {highSeen, scsiIn})
        else begin
            errCount++;
            $error("ERROR fifoIn got %h expected %h", fifoIn, {highSeen, scsiIn});
        end

    // Back-pressure holds the second ack and the write
    assert property (@(posedge CLK) disable iff (rst)
        $past(s2f) && $past(firstDone) && $past(fifoFull) && !$past(scsiAck) |-> !scsiAck)
        else begin
            errCount++;
            $error("Second half acked while the FIFO was full");
        end
    assert property (@(posedge CLK) disable iff (rst) s2f && $past(fifoFull) |-> !fifoWrite)
        else begin
            errCount++;
            $error("FIFO written while it was full");
        end

    // Outbound halves come high first, and the low half pops the FIFO
    assert property (@(posedge CLK) disable iff (rst) f2s && ackRise |->
        scsiOut == (outFirstDone ? fifoRdData[15:0] : fifoRdData[31:16]))
        else begin
            errCount++;
            $error("ERROR scsiOut got %h expected %h", scsiOut,
                outFirstDone ? fifoRdData[15:0] : fifoRdData[31:16]);
        end
    assert property (@(posedge CLK) disable iff (rst)
        fifoRead == (f2s && ackRise && outFirstDone))
        else begin
            errCount++;
            $error("fifoRead did not match the low-half ack");
        end

    // CPU side feeds the FIFO when the SCSI side does not
    assert property (@(posedge CLK) disable iff (rst) !s2f |-> fifoIn == laneModel)
        else begin
            errCount++;
            $error("ERROR fifoIn got %h expected %h", fifoIn, laneModel);
        end
    assert property (@(posedge CLK) disable iff (rst) !s2f |-> fifoWrite == cpuWrite)
        else begin
            errCount++;
            $error("ERROR fifoWrite got %h expected %h", fifoWrite, cpuWrite);
        end

    // Read mux and registered output enable
    assert property (@(posedge CLK) disable iff (rst) cpuRdData == rdExpected)
        else begin
            errCount++;
            $error("ERROR cpuRdData got %h expected %h", cpuRdData, rdExpected);
        end
    assert property (@(posedge CLK) disable iff (rst) dataOe == oeExpected)
        else begin
            errCount++;
            $error("ERROR dataOe got %h expected %h", dataOe, oeExpected);
        end

endmodule

/* bench/scsiDatapathTb.sv */
// SCSI data path testbench

`timescale 1ns/1ps

module scsiDatapathTb;
    import dmaPkg::*;

    logic    CLK = 1'b0;
    logic    rst;
    busWord  busIn;
    logic    laneHigh, laneLow, s2f, f2s, s2cpu;
    logic    scsiReq, scsiAck;
    scsiHalf scsiIn, scsiOut;
    logic    fifoFull, fifoRead, fifoWrite;
    busWord  fifoIn, regData, cpuRdData;
    logic    cpuWrite, cpuSelect, cpuRead, busOwned, dmaDir, dataOe;

    // FIFO outputs start empty and are then updated by the FIFO model
    logic    fifoEmpty = 1'b1;
    busWord  fifoRdData = '0;

    int      seed = 45979;
    int      failCount = 0;
    int      writeCount = 0;
    int      popCount = 0;
    int      testErrors;
    // The FIFO model holds inbound words and words queued for the SCSI port
    busWord  inQ[$];
    busWord  outQ[$];

    always #4 CLK = ~CLK;

    scsiDatapath DUT (.*);

    bind scsiDatapath scsiDatapath_checker chk (.*);

    // FIFO model takes writes while not full and pops on fifoRead
    always @(posedge CLK) begin
        if (!rst && fifoWrite && !fifoFull) begin
            inQ.push_back(fifoIn);
            writeCount++;
        end
        if (!rst && fifoRead && outQ.size() > 0) begin
            void'(outQ.pop_front());
            popCount++;
        end
        fifoEmpty  <= (outQ.size() == 0);
        fifoRdData <= (outQ.size() > 0) ? outQ[0] : '0;
    end

    function automatic int totalErrors();
        return failCount + DUT.chk.errCount;
    endfunction

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic waitAck(input logic level, input string what);
        int n;
        n = 0;
        while (scsiAck !== level && n < 200) begin
            @(posedge CLK);
            n++;
        end
        if (scsiAck !== level) timeoutFail(what);
    endtask

    task automatic checkWord(input string name, input busWord got, input busWord exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            failCount++;
        end
    endtask

    // SCSI device sends one half through the full four-phase cycle
    task automatic sendHalf(input scsiHalf value);
        @(posedge CLK);
        scsiIn  <= value;
        scsiReq <= 1'b1;
        waitAck(1'b1, "ack of an inbound half");
        scsiReq <= 1'b0;
        waitAck(1'b0, "ack release of an inbound half");
    endtask

    task automatic receiveHalf(output scsiHalf value);
        @(posedge CLK);
        scsiReq <= 1'b1;
        waitAck(1'b1, "ack of an outbound half");
        value = scsiOut;
        scsiReq <= 1'b0;
        waitAck(1'b0, "ack release of an outbound half");
    endtask

    task automatic endTest(input int num, input string name);
        $display("Test %0d %s finished with %0d errors", num, name, totalErrors() - testErrors);
        testErrors = totalErrors();
    endtask

    initial begin
        scsiHalf hi;
        scsiHalf lo;
        busWord  word;
        busWord  expQ[$];
        int      startWrites;

        rst = 1'b1;
        busIn = '0;
        laneHigh = 1'b0;
        laneLow = 1'b0;
        s2f = 1'b0;
        f2s = 1'b0;
        s2cpu = 1'b0;
        scsiReq = 1'b0;
        scsiIn = '0;
        fifoFull = 1'b0;
        cpuWrite = 1'b0;
        regData = '0;
        cpuSelect = 1'b0;
        cpuRead = 1'b0;
        busOwned = 1'b0;
        dmaDir = 1'b0;
        testErrors = 0;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;

        // Inbound words are assembled high half first
        @(posedge CLK);
        s2f <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            hi = scsiHalf'($random(seed));
            lo = scsiHalf'($random(seed));
            expQ.push_back({hi, lo});
            sendHalf(hi);
            sendHalf(lo);
        end
        checkWord("writeCount", busWord'(writeCount), 32'd3);
        for (int i = 0; i < 3 && i < inQ.size(); i++) checkWord("fifoIn", inQ[i], expQ[i]);
        endTest(1, "SCSI to FIFO");

        // Outbound words leave the SCSI port high half first
        @(posedge CLK);
        s2f <= 1'b0;
        f2s <= 1'b1;
        expQ.delete();
        for (int i = 0; i < 2; i++) begin
            word = busWord'($random(seed));
            expQ.push_back(word);
            outQ.push_back(word);
        end
        for (int i = 0; i < 2; i++) begin
            receiveHalf(hi);
            receiveHalf(lo);
            checkWord("scsiOut word", {hi, lo}, expQ[i]);
        end
        checkWord("popCount", busWord'(popCount), 32'd2);
        endTest(2, "FIFO to SCSI");

        // A reset while a word is half done drops the held half
        @(posedge CLK);
        f2s <= 1'b0;
        s2f <= 1'b1;
        sendHalf(scsiHalf'($random(seed)));
        rst <= 1'b1;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;
        for (int i = 0; i < 4; i++) sendHalf(scsiHalf'($random(seed)));
        endTest(3, "Handshake rule");

        // CPU lanes captured on separate cycles feed the FIFO
        @(posedge CLK);
        s2f <= 1'b0;
        startWrites = writeCount;
        word = busWord'($random(seed));
        busIn <= word;
        laneHigh <= 1'b1;
        @(posedge CLK);
        laneHigh <= 1'b0;
        laneLow <= 1'b1;
        busIn <= busWord'($random(seed));
        @(posedge CLK);
        word = {word[31:16], busIn[15:0]};
        laneLow <= 1'b0;
        cpuWrite <= 1'b1;
        @(posedge CLK);
        cpuWrite <= 1'b0;
        @(posedge CLK);
        checkWord("writeCount", busWord'(writeCount - startWrites), 32'd1);
        checkWord("fifoIn", inQ[$], word);
        endTest(4, "CPU lanes");

        // Random read selects and bus enables drive the read mux and enable decode
        for (int i = 0; i < 24; i++) begin
            @(posedge CLK);
            s2cpu <= $random(seed) % 2 != 0;
            regData <= busWord'($random(seed));
            cpuSelect <= $random(seed) % 2 != 0;
            cpuRead <= $random(seed) % 2 != 0;
            busOwned <= $random(seed) % 2 != 0;
            dmaDir <= $random(seed) % 2 != 0;
        end
        endTest(5, "Read selection and output enable");

        // The second half waits while the FIFO is full
        @(posedge CLK);
        s2f <= 1'b1;
        fifoFull <= 1'b1;
        hi = scsiHalf'($random(seed));
        lo = scsiHalf'($random(seed));
        sendHalf(hi);
        startWrites = writeCount;
        @(posedge CLK);
        scsiIn <= lo;
        scsiReq <= 1'b1;
        for (int i = 0; i < 12; i++) begin
            @(posedge CLK);
            if (scsiAck) begin
                $display("Second half was acked while the FIFO was full");
                failCount++;
            end
        end
        fifoFull <= 1'b0;
        waitAck(1'b1, "ack after the FIFO drained");
        scsiReq <= 1'b0;
        waitAck(1'b0, "ack release after back-pressure");
        checkWord("writeCount", busWord'(writeCount - startWrites), 32'd1);
        checkWord("fifoIn", inQ[$], {hi, lo});
        endTest(6, "Back-pressure");

        $display("Tests run: 6, errors: %0d", totalErrors());
        if (totalErrors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
src/dmaPkg.sv
src/cpuLaneLatch.sv
src/scsiWordPacker.sv
src/dataRouter.sv
src/scsiDatapath.sv
bench/scsiDatapath_checker.sv
bench/scsiDatapathTb.sv

/* Makefile */
TOP = scsiDatapathTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
